//--- verilog/eth_stream_pkg.sv
package eth_stream_pkg;

  localparam int eth_mtu_bytes = 1500;
  localparam int ip_hdr_bytes  = 20;
  localparam int udp_hdr_bytes = 8;

  localparam int len_w   = 16;
  localparam int total_w = 32;

  // largest udp payload that fits one frame
  localparam logic [len_w-1:0] max_pkt_bytes =
    len_w'(eth_mtu_bytes - ip_hdr_bytes - udp_hdr_bytes);

  localparam int gap_cycles = 128;  // idle cycles after each packet

  localparam int fifo_addr_w = 11;
  localparam int fifo_depth  = 1 << fifo_addr_w;
  localparam int fifo_cnt_w  = 12;  // one bit more than the address

  localparam int sample_w = 16;
  localparam int byte_w   = 8;

  // send controller states
  localparam int ctrl_state_w = 4;
  localparam logic [ctrl_state_w-1:0] st_idle         = 4'd0;
  localparam logic [ctrl_state_w-1:0] st_burst_wait   = 4'd1;
  localparam logic [ctrl_state_w-1:0] st_burst_send   = 4'd2;
  localparam logic [ctrl_state_w-1:0] st_burst_gap    = 4'd3;
  localparam logic [ctrl_state_w-1:0] st_burst_length = 4'd4;
  localparam logic [ctrl_state_w-1:0] st_stream_wait  = 4'd5;
  localparam logic [ctrl_state_w-1:0] st_stream_send  = 4'd6;
  localparam logic [ctrl_state_w-1:0] st_stream_done  = 4'd7;
  localparam logic [ctrl_state_w-1:0] st_stream_gap   = 4'd8;

endpackage

//--- verilog/sample_byte_splitter.sv
`timescale 1ns/1ps

module sample_byte_splitter import eth_stream_pkg::*; (
  input  logic                clk125M,
  input  logic                reset_n,
  input  logic                sample_valid,
  input  logic [sample_w-1:0] sample_data,
  output logic                fifo_wr,
  output logic [byte_w-1:0]   fifo_din
);

  logic [byte_w-1:0] low_byte;
  logic              pending;  // low byte still to be written

  always_ff @(posedge clk125M or negedge reset_n) begin
    if (!reset_n) begin
      fifo_wr <= 1'b0;
      pending <= 1'b0;
    end else begin
      fifo_wr <= 1'b0;
      if (pending) begin
        fifo_wr <= 1'b1;
        pending <= 1'b0;
      end else if (sample_valid) begin
        fifo_wr <= 1'b1;
        pending <= 1'b1;
      end
    end
  end

  // byte path to the fifo
  always_ff @(posedge clk125M) begin
    if (pending) begin
      fifo_din <= low_byte;
    end else if (sample_valid) begin
      fifo_din <= sample_data[sample_w-1:byte_w];  // high byte first
      low_byte <= sample_data[byte_w-1:0];
    end
  end

endmodule

//--- verilog/sample_byte_fifo.sv
`timescale 1ns/1ps

module sample_byte_fifo import eth_stream_pkg::*; (
  input  logic                  clk125M,
  input  logic                  reset_n,
  input  logic                  fifo_wr,
  input  logic [byte_w-1:0]     fifo_din,
  input  logic                  fifo_rd,
  output logic [byte_w-1:0]     fifo_dout,
  output logic [fifo_cnt_w-1:0] fifo_rd_cnt,
  output logic                  overflow
);

  logic [byte_w-1:0]      mem [0:fifo_depth-1];
  logic [fifo_addr_w-1:0] wr_ptr;
  logic [fifo_addr_w-1:0] rd_ptr;
  logic                   full;
  logic                   wr_ok;
  logic                   rd_ok;

  assign full  = (fifo_rd_cnt == fifo_cnt_w'(fifo_depth));
  assign wr_ok = fifo_wr && !full;  // drop when full
  assign rd_ok = fifo_rd && (fifo_rd_cnt != '0);

  always_ff @(posedge clk125M) begin
    if (wr_ok)
      mem[wr_ptr] <= fifo_din;
    if (rd_ok)
      fifo_dout <= mem[rd_ptr];
  end

  always_ff @(posedge clk125M or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_rd_cnt <= '0;
      overflow    <= 1'b0;
    end else begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   fifo_rd_cnt <= fifo_rd_cnt + 1'b1;
        2'b01:   fifo_rd_cnt <= fifo_rd_cnt - 1'b1;
        default: fifo_rd_cnt <= fifo_rd_cnt;
      endcase
      if (fifo_wr && full)
        overflow <= 1'b1;  // sticky until reset
    end
  end

endmodule

//--- verilog/eth_send_ctrl.sv
`timescale 1ns/1ps

module eth_send_ctrl import eth_stream_pkg::*; (
  input  logic                  clk125M,
  input  logic                  reset_n,
  input  logic                  eth_tx_done,
  input  logic                  restart_req,
  input  logic                  stream_mode,
  input  logic [fifo_cnt_w-1:0] fifo_rd_cnt,
  input  logic [total_w-1:0]    total_data_num,
  output logic                  pkt_tx_en,
  output logic [len_w-1:0]      pkt_length
);

  logic [ctrl_state_w-1:0]            state;
  logic [total_w-1:0]                 data_num;  // samples still to send
  logic [$clog2(gap_cycles+1)-1:0]    gap_cnt;
  logic [len_w-1:0]                   fifo_even_len;

  assign fifo_even_len = len_w'({fifo_rd_cnt[fifo_cnt_w-1:1], 1'b0});

  // two bytes per sample up to one full payload
  function automatic logic [len_w-1:0] burst_len(input logic [total_w-1:0] n);
    if (n >= total_w'(max_pkt_bytes >> 1))
      return max_pkt_bytes;
    return {n[len_w-2:0], 1'b0};
  endfunction

  always_ff @(posedge clk125M or negedge reset_n) begin
    if (!reset_n) begin
      state      <= st_idle;
      pkt_tx_en  <= 1'b0;
      pkt_length <= '0;
      data_num   <= '0;
      gap_cnt    <= '0;
    end else begin
      pkt_tx_en <= 1'b0;
      case (state)
        st_idle: begin
          gap_cnt <= '0;
          if (stream_mode) begin
            pkt_length <= max_pkt_bytes;
            state      <= st_stream_wait;
          end else if (restart_req && total_data_num != '0) begin
            data_num   <= total_data_num;
            pkt_length <= burst_len(total_data_num);
            state      <= st_burst_wait;
          end
        end

        st_burst_wait: begin
          // last sample may still be in the splitter
          if (fifo_rd_cnt >= pkt_length - len_w'(2)) begin
            pkt_tx_en <= 1'b1;
            state     <= st_burst_send;
          end
        end

        st_burst_send: begin
          if (eth_tx_done) begin
            data_num <= data_num - (pkt_length >> 1);
            state    <= st_burst_gap;
          end
        end

        st_burst_gap: begin
          if (gap_cnt >= gap_cycles) begin
            gap_cnt <= '0;
            state   <= st_burst_length;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end

        st_burst_length: begin
          if (data_num != '0) begin
            pkt_length <= burst_len(data_num);
            state      <= st_burst_wait;
          end else if (stream_mode) begin
            pkt_length <= max_pkt_bytes;
            state      <= st_stream_wait;
          end else begin
            state <= st_idle;
          end
        end

        st_stream_wait: begin
          if (stream_mode) begin
            if (fifo_rd_cnt >= max_pkt_bytes) begin
              pkt_length <= max_pkt_bytes;
              state      <= st_stream_send;
            end
          end else if (fifo_rd_cnt >= fifo_cnt_w'(2)) begin
            // flush the even part of what is left
            if (fifo_even_len > max_pkt_bytes)
              pkt_length <= max_pkt_bytes;
            else
              pkt_length <= fifo_even_len;
            state <= st_stream_send;
          end else begin
            state <= st_idle;
          end
        end

        st_stream_send: begin
          pkt_tx_en <= 1'b1;
          state     <= st_stream_done;
        end

        st_stream_done: begin
          if (eth_tx_done)
            state <= st_stream_gap;
        end

        st_stream_gap: begin
          if (gap_cnt >= gap_cycles) begin
            gap_cnt <= '0;
            if (stream_mode || fifo_rd_cnt >= fifo_cnt_w'(2))
              state <= st_stream_wait;
            else
              state <= st_idle;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- verilog/udp_payload_tx.sv
`timescale 1ns/1ps

module udp_payload_tx import eth_stream_pkg::*; (
  input  logic                  clk125M,
  input  logic                  reset_n,
  input  logic                  pkt_tx_en,
  input  logic [len_w-1:0]      pkt_length,
  input  logic [byte_w-1:0]     fifo_dout,
  input  logic [fifo_cnt_w-1:0] fifo_rd_cnt,
  output logic                  fifo_rd,
  output logic                  payload_valid,
  output logic [byte_w-1:0]     payload_byte,
  output logic                  payload_last,
  output logic                  eth_tx_done
);

  logic [len_w-1:0] rd_left;  // bytes of this packet not yet read

  // count already reflects the previous read
  assign fifo_rd = (rd_left != '0) && (fifo_rd_cnt != '0);

  assign payload_byte = fifo_dout;  // fifo data lands with payload_valid

  always_ff @(posedge clk125M or negedge reset_n) begin
    if (!reset_n) begin
      rd_left       <= '0;
      payload_valid <= 1'b0;
      payload_last  <= 1'b0;
      eth_tx_done   <= 1'b0;
    end else begin
      if (pkt_tx_en)
        rd_left <= pkt_length;
      else if (fifo_rd)
        rd_left <= rd_left - 1'b1;
      payload_valid <= fifo_rd;
      payload_last  <= fifo_rd && (rd_left == len_w'(1));
      eth_tx_done   <= payload_last;  // one cycle after the last byte
    end
  end

endmodule

//--- verilog/eth_capture_top.sv
`timescale 1ns/1ps

module eth_capture_top import eth_stream_pkg::*; (
  input  logic                clk125M,
  input  logic                reset_n,
  input  logic                sample_valid,
  input  logic [sample_w-1:0] sample_data,
  input  logic                restart_req,
  input  logic                stream_mode,
  input  logic [total_w-1:0]  total_data_num,
  output logic                payload_valid,
  output logic [byte_w-1:0]   payload_byte,
  output logic                payload_last,
  output logic [len_w-1:0]    pkt_length,
  output logic                eth_tx_done,
  output logic                overflow
);

  logic                  fifo_wr;
  logic [byte_w-1:0]     fifo_din;
  logic                  fifo_rd;
  logic [byte_w-1:0]     fifo_dout;
  logic [fifo_cnt_w-1:0] fifo_rd_cnt;
  logic                  pkt_tx_en;

  sample_byte_splitter splitter_i (
    .clk125M      (clk125M),
    .reset_n      (reset_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .fifo_wr      (fifo_wr),
    .fifo_din     (fifo_din)
  );

  sample_byte_fifo fifo_i (
    .clk125M     (clk125M),
    .reset_n     (reset_n),
    .fifo_wr     (fifo_wr),
    .fifo_din    (fifo_din),
    .fifo_rd     (fifo_rd),
    .fifo_dout   (fifo_dout),
    .fifo_rd_cnt (fifo_rd_cnt),
    .overflow    (overflow)
  );

  eth_send_ctrl ctrl_i (
    .clk125M        (clk125M),
    .reset_n        (reset_n),
    .eth_tx_done    (eth_tx_done),
    .restart_req    (restart_req),
    .stream_mode    (stream_mode),
    .fifo_rd_cnt    (fifo_rd_cnt),
    .total_data_num (total_data_num),
    .pkt_tx_en      (pkt_tx_en),
    .pkt_length     (pkt_length)
  );

  udp_payload_tx tx_i (
    .clk125M       (clk125M),
    .reset_n       (reset_n),
    .pkt_tx_en     (pkt_tx_en),
    .pkt_length    (pkt_length),
    .fifo_dout     (fifo_dout),
    .fifo_rd_cnt   (fifo_rd_cnt),
    .fifo_rd       (fifo_rd),
    .payload_valid (payload_valid),
    .payload_byte  (payload_byte),
    .payload_last  (payload_last),
    .eth_tx_done   (eth_tx_done)
  );

endmodule

//--- bench/eth_capture_assert.sv
`timescale 1ns/1ps

module eth_capture_assert import eth_stream_pkg::*; (
  input logic                clk125M,
  input logic                reset_n,
  input logic                restart_req,
  input logic                stream_mode,
  input logic [total_w-1:0]  total_data_num,
  input logic                pkt_tx_en,
  input logic [len_w-1:0]    pkt_length,
  input logic                payload_valid,
  input logic [byte_w-1:0]   payload_byte,
  input logic                payload_last,
  input logic                eth_tx_done,
  input logic                overflow
);

  int unsigned         fail_cnt = 0;
  logic [total_w-1:0]  burst_left;   // samples still owed by the burst
  logic [len_w-1:0]    pkt_bytes;    // bytes seen so far in this packet
  logic [sample_w-1:0] next_sample;
  logic                low_next;     // next byte is the low half
  int unsigned         idle_cnt;     // cycles since eth_tx_done
  logic [len_w-1:0]    burst_len;
  logic [byte_w-1:0]   exp_byte;
  logic                out_quiet;

  // min of a full payload and two bytes per remaining sample
  assign burst_len = (burst_left * 2 >= total_w'(max_pkt_bytes)) ? max_pkt_bytes
                                                                  : len_w'(burst_left * 2);
  assign exp_byte  = low_next ? next_sample[byte_w-1:0] : next_sample[sample_w-1:byte_w];
  assign out_quiet = !(payload_valid || payload_last || eth_tx_done || overflow);

  task automatic raise_error(input string msg);
    fail_cnt++;
    $error("%s", msg);
  endtask

  always_ff @(posedge clk125M or negedge reset_n) begin
    if (!reset_n) begin
      burst_left  <= '0;
      pkt_bytes   <= '0;
      next_sample <= '0;
      low_next    <= 1'b0;
      idle_cnt    <= gap_cycles;
    end else begin
      if (restart_req)
        burst_left <= total_data_num;
      else if (eth_tx_done && burst_left != '0)
        burst_left <= burst_left - total_w'(pkt_length / 2);
      if (payload_valid) begin
        pkt_bytes <= payload_last ? '0 : pkt_bytes + 1'b1;
        low_next  <= !low_next;
        if (low_next)
          next_sample <= next_sample + 1'b1;
      end
      if (eth_tx_done)
        idle_cnt <= 0;
      else if (idle_cnt < gap_cycles)
        idle_cnt <= idle_cnt + 1;
    end
  end

  reset_quiet: assert property (@(posedge clk125M) !reset_n |-> out_quiet ##1 out_quiet)
    else raise_error("outputs were active during reset or right after it");

  no_overflow: assert property (@(posedge clk125M) !overflow)
    else raise_error("the FIFO overflow flag was set");

  pkt_len_range: assert property (@(posedge clk125M) disable iff (!reset_n)
    pkt_tx_en |-> pkt_length != '0 && !pkt_length[0] && pkt_length <= max_pkt_bytes)
    else raise_error($sformatf("ERROR pkt_len_range expected even 2..%0d actual %0d",
                               max_pkt_bytes, $sampled(pkt_length)));

  burst_len_rule: assert property (@(posedge clk125M) disable iff (!reset_n)
    pkt_tx_en && burst_left != '0 |-> pkt_length == burst_len)
    else raise_error($sformatf("ERROR burst_len_rule expected %0d actual %0d",
                               $sampled(burst_len), $sampled(pkt_length)));

  stream_len_rule: assert property (@(posedge clk125M) disable iff (!reset_n)
    pkt_tx_en && stream_mode |-> pkt_length == max_pkt_bytes)
    else raise_error($sformatf("ERROR stream_len_rule expected %0d actual %0d",
                               max_pkt_bytes, $sampled(pkt_length)));

  byte_count: assert property (@(posedge clk125M) disable iff (!reset_n)
    payload_last |-> payload_valid && pkt_bytes + 1'b1 == pkt_length)
    else raise_error($sformatf("ERROR byte_count expected %0d actual %0d",
                               $sampled(pkt_length), $sampled(pkt_bytes) + 1));

  content: assert property (@(posedge clk125M) disable iff (!reset_n)
    payload_valid |-> payload_byte == exp_byte)
    else raise_error($sformatf("ERROR content expected %02h actual %02h",
                               $sampled(exp_byte), $sampled(payload_byte)));

  pkt_gap: assert property (@(posedge clk125M) disable iff (!reset_n)
    payload_valid && pkt_bytes == '0 |-> idle_cnt >= gap_cycles)
    else raise_error($sformatf("ERROR pkt_gap expected >= %0d actual %0d",
                               gap_cycles + 1, $sampled(idle_cnt) + 1));

endmodule

bind eth_capture_top eth_capture_assert checks_i (.*);

//--- bench/eth_capture_tb.sv
`timescale 1ns/1ps

module eth_capture_tb import eth_stream_pkg::*; ();

  localparam int timeout_cycles = 20000;
  localparam int run_limit      = 200000;

  logic                clk125M;
  logic                reset_n;
  logic                sample_valid;
  logic [sample_w-1:0] sample_data;
  logic                restart_req;
  logic                stream_mode;
  logic [total_w-1:0]  total_data_num;
  logic                payload_valid;
  logic [byte_w-1:0]   payload_byte;
  logic                payload_last;
  logic [len_w-1:0]    pkt_length;
  logic                eth_tx_done;
  logic                overflow;
  int                  next_sample = 0;
  int                  byte_cnt = 0;
  int                  last_cnt = 0;

  eth_capture_top dut_i (.*);

  initial begin
    clk125M = 1'b0;
    forever #4 clk125M = ~clk125M;
  end

  always @(posedge clk125M) begin
    if (payload_valid)
      byte_cnt <= byte_cnt + 1;
    if (payload_valid && payload_last)
      last_cnt <= last_cnt + 1;
  end

  // incrementing samples 2 to 5 cycles apart
  task automatic send_samples(input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = 2 + int'($urandom % 4);
      @(posedge clk125M);
      sample_valid <= 1'b1;
      sample_data  <= sample_w'(next_sample);
      next_sample++;
      @(posedge clk125M);
      sample_valid <= 1'b0;
      repeat (gap - 2) @(posedge clk125M);
    end
  endtask

  task automatic start_burst(input int n);
    @(posedge clk125M);
    total_data_num <= n;
    restart_req    <= 1'b1;
    @(posedge clk125M);
    restart_req <= 1'b0;
  endtask

  task automatic wait_packets(input int lasts, input int bytes, input string what);
    int cyc;
    cyc = 0;
    while ((last_cnt < lasts || byte_cnt < bytes) && cyc < timeout_cycles) begin
      @(posedge clk125M);
      cyc++;
    end
    if (last_cnt < lasts || byte_cnt < bytes) begin
      $display("Test FAILED");
      $fatal(1, "timeout: %s stalled after %0d packets", what, last_cnt);
    end
  endtask

  // stop at the first checker error
  initial begin
    int cyc;
    cyc = 0;
    while (dut_i.checks_i.fail_cnt == 0 && cyc < run_limit) begin
      @(posedge clk125M);
      cyc++;
    end
    $display("Test FAILED");
    if (cyc >= run_limit)
      $fatal(1, "the run did not finish within %0d cycles", run_limit);
    else
      $fatal(1, "a checker assertion failed");
  end

  initial begin
    reset_n        = 1'b0;
    sample_valid   = 1'b0;
    sample_data    = '0;
    restart_req    = 1'b0;
    stream_mode    = 1'b0;
    total_data_num = '0;
    void'($urandom(32'h4722));
    repeat (4) @(posedge clk125M);
    reset_n <= 1'b1;
    repeat (2) @(posedge clk125M);

    start_burst(1000);  // 1472 then 528 bytes
    send_samples(1000);
    wait_packets(2, 2000, "burst of 1000 samples");
    repeat (gap_cycles + 8) @(posedge clk125M);

    start_burst(3);
    send_samples(3);
    wait_packets(3, 2006, "burst of 3 samples");
    repeat (gap_cycles + 8) @(posedge clk125M);

    @(posedge clk125M);
    stream_mode <= 1'b1;
    send_samples(2000);
    repeat (4) @(posedge clk125M);  // last low byte lands in the FIFO
    stream_mode <= 1'b0;
    wait_packets(6, 6006, "stream phase and flush");
    repeat (gap_cycles + 8) @(posedge clk125M);

    if (dut_i.checks_i.fail_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "the checker reported errors");
    end
  end

endmodule

//--- files.f
verilog/eth_stream_pkg.sv
verilog/sample_byte_splitter.sv
verilog/sample_byte_fifo.sv
verilog/eth_send_ctrl.sv
verilog/udp_payload_tx.sv
verilog/eth_capture_top.sv
bench/eth_capture_assert.sv
bench/eth_capture_tb.sv
